// File: filelist.f
+incdir+logic
logic/opq_pkg.sv
logic/opq_fifo.sv
logic/opq_input_buffer.sv
logic/opq_extender.sv
logic/opq_issue_ctrl.sv
logic/operand_queue.sv
sim/operand_queue_assert.sv
sim/tb_operand_queue.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_operand_queue
FILELIST  := filelist.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
SRCS      := $(wildcard logic/*.sv logic/*.svh sim/*.sv)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only if the simulator prints the pass line
run: $(BIN)
	./$(BIN) | tee /dev/stderr | grep -q "^Test passed$$"

clean:
	rm -rf $(OBJ_DIR)

// File: sim/tb_operand_queue.sv
`timescale 1ns/100ps
`default_nettype none
`include "opq_params.svh"

module tb_operand_queue import opq_pkg::*; ();

  localparam int unsigned NUM_CMDS   = 60;
  localparam int unsigned MAX_CYCLES = 40 * NUM_CMDS + 100;

  logic       clk_i;
  logic       rst_ni;
  opq_cmd_t   cmd_i;
  logic       cmd_valid_i;
  data_word_t operand_i;
  logic       operand_valid_i;
  logic       operand_issued_i;
  logic       ready_o;
  data_word_t operand_o;
  target_fu_e target_fu_o;
  logic       valid_o;
  logic       operand_ready_i;

  // Sent commands and words, in order
  opq_cmd_t    cmd_q[$];
  data_word_t  word_q[$];
  int unsigned pushed_cnt = 0;
  int unsigned done_cnt = 0;
  int unsigned cycle_cnt = 0;
  int unsigned beat_idx = 0;
  // Expected outstanding credits after the last clock edge
  int          credit_exp = 0;
  logic        ready_smp = 1'b0;
  logic        ready_seen_low = 1'b0;
  logic [31:0] cons_seed;

  operand_queue i_dut (.*);

  function automatic logic [31:0] lcg_next(logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Nominal widening factor of the conversion mode
  function automatic int unsigned conv_factor(opq_cmd_t cmd);
    case (cmd.conv)
      SEXT2, ZEXT2: return 2;
      SEXT4, ZEXT4: return 4;
      SEXT8, ZEXT8: return 8;
      default:      return 1;
    endcase
  endfunction

  // Expected output for beat sub of one source word
  function automatic data_word_t ref_operand(opq_cmd_t cmd, data_word_t src, int unsigned sub);
    int unsigned e;
    int unsigned f;
    data_word_t  res;
    data_word_t  elem;
    data_word_t  mask;
    e = 8 << cmd.eew;
    f = conv_factor(cmd);
    res = '0;
    // Result wider than a word is not a real widening
    if (f == 1 || e * f > 64) begin
      return src;
    end
    mask = (64'd1 << e) - 64'd1;
    for (int unsigned j = 0; j < 64 / (e * f); j++) begin
      elem = (src >> (sub * 64 / f + j * e)) & mask;
      if (cmd.conv inside {SEXT2, SEXT4, SEXT8} && elem[e-1]) begin
        elem = elem | ~mask;
      end
      if (e * f < 64) begin
        elem = elem & ((64'd1 << (e * f)) - 64'd1);
      end
      res = res | (elem << (j * e * f));
    end
    return res;
  endfunction

  task automatic check_word(string name, data_word_t got, data_word_t exp);
    if (got !== exp) begin
      $display("ERROR %0t %s: got %h expected %h", $time, name, got, exp);
      $display("Test failed");
      $fatal(1);
    end
  endtask

  task automatic check_target(string name, target_fu_e got, target_fu_e exp);
    if (got !== exp) begin
      $display("ERROR %0t %s: got %s expected %s", $time, name, got.name(), exp.name());
      $display("Test failed");
      $fatal(1);
    end
  endtask

  task automatic check_ready(string name, logic got, logic exp);
    if (got !== exp) begin
      $display("ERROR %0t %s: got %b expected %b", $time, name, got, exp);
      $display("Test failed");
      $fatal(1);
    end
  endtask

  task automatic fail_now(string what);
    $display("%0t %s", $time, what);
    $display("Test failed");
    $fatal(1);
  endtask

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    logic [31:0] seed;
    opq_cmd_t    cmd;
    int unsigned flog;
    int unsigned nwords;
    rst_ni           = 1'b0;
    cmd_i            = '0;
    cmd_valid_i      = 1'b0;
    operand_i        = '0;
    operand_valid_i  = 1'b0;
    operand_issued_i = 1'b0;
    operand_ready_i  = 1'b0;
    seed             = 32'h294b;
    repeat (4) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    if (valid_o !== 1'b0) fail_now("valid_o is not low after reset");
    if (ready_o !== 1'b1) fail_now("ready_o is not high after reset");
    for (int unsigned n = 0; n < NUM_CMDS; n++) begin
      @(posedge clk_i);
      operand_valid_i <= 1'b0;
      // Command FIFO must not overflow
      while (pushed_cnt - done_cnt >= `OPQ_CMD_DEPTH) @(posedge clk_i);
      seed = lcg_next(seed);
      cmd.conv = (seed[18:16] == 3'd7) ? CONV_NONE : conv_e'(seed[18:16]);
      flog = $clog2(conv_factor(cmd));
      seed = lcg_next(seed);
      // Only pairs whose result fits in one word
      cmd.eew       = eew_e'(2'(seed[17:16] % (4 - flog)));
      // First every mode with every width once, unsupported pairs included
      if (n < 28) begin
        cmd.conv = conv_e'(n / 4);
        cmd.eew  = eew_e'(n % 4);
      end
      cmd.vl        = vl_t'(seed[23:20] % 8 + 1);
      cmd.target_fu = target_fu_e'(seed[24]);
      cmd_i       <= cmd;
      cmd_valid_i <= 1'b1;
      cmd_q.push_back(cmd);
      pushed_cnt++;
      nwords = (int'(cmd.vl) * (8 << cmd.eew) + 63) / 64;
      for (int unsigned w = 0; w < nwords; w++) begin
        @(posedge clk_i);
        cmd_valid_i     <= 1'b0;
        operand_valid_i <= 1'b0;
        // Previous cycle had no issue, so a high ready still holds
        while (!ready_smp) @(posedge clk_i);
        operand_issued_i <= 1'b1;
        @(posedge clk_i);
        operand_issued_i <= 1'b0;
        seed = lcg_next(seed);
        operand_i       <= {seed, lcg_next(seed)};
        operand_valid_i <= 1'b1;
        word_q.push_back({seed, lcg_next(seed)});
        seed = lcg_next(seed);
        if (seed[16]) begin
          @(posedge clk_i);
          operand_valid_i <= 1'b0;
        end
      end
    end
    @(posedge clk_i);
    cmd_valid_i     <= 1'b0;
    operand_valid_i <= 1'b0;
    while (done_cnt < NUM_CMDS) @(posedge clk_i);
    if (ready_seen_low && cmd_q.size() == 0 && word_q.size() == 0) begin
      $display("Test passed");
      $finish;
    end else begin
      $display("credits never ran out or words were left over");
      $display("Test failed");
      $fatal(1);
    end
  end

  // Random consumer stalls
  initial cons_seed = lcg_next(32'h294b);

  always @(posedge clk_i) begin
    cons_seed = lcg_next(cons_seed);
    operand_ready_i <= rst_ni && (cons_seed[17:16] != 2'd0);
  end

  ////////////////////////////////////////////////////////////////////////////
  // Scoreboard
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge clk_i) begin
    opq_cmd_t    c;
    int unsigned e;
    int unsigned f;
    int unsigned epb;
    int unsigned nbeats;
    logic        pop_now;
    ready_smp = ready_o;
    if (rst_ni && !ready_o) ready_seen_low = 1'b1;
    // Ready while fewer words than the depth are outstanding
    if (rst_ni) check_ready("ready_o", ready_o, credit_exp < `OPQ_DATA_DEPTH);
    pop_now = 1'b0;
    if (rst_ni && valid_o && operand_ready_i) begin
      if (cmd_q.size() == 0) fail_now("transfer without a pending command");
      c = cmd_q[0];
      e = 8 << c.eew;
      f = conv_factor(c);
      if (e * f > 64) f = 1;
      epb    = 64 / (e * f);
      nbeats = (int'(c.vl) + epb - 1) / epb;
      if (beat_idx / f >= word_q.size()) fail_now("transfer without a matching word");
      check_word("operand_o", operand_o, ref_operand(c, word_q[beat_idx / f], beat_idx % f));
      check_target("target_fu_o", target_fu_o, c.target_fu);
      beat_idx++;
      // Source word used up after F beats
      pop_now = (beat_idx % f == 0);
      // Last beat drops every word of the command
      if (beat_idx == nbeats) begin
        pop_now = 1'b1;
        for (int unsigned k = 0; k < (nbeats + f - 1) / f; k++) begin
          void'(word_q.pop_front());
        end
        void'(cmd_q.pop_front());
        done_cnt++;
        beat_idx = 0;
      end
    end
    // Credit count after the coming edge
    if (rst_ni) credit_exp = credit_exp + int'(operand_issued_i) - int'(pop_now);
  end

  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt > MAX_CYCLES) fail_now("timeout waiting for all commands to finish");
  end

endmodule

`default_nettype wire

// File: sim/operand_queue_assert.sv
`timescale 1ns/100ps
`default_nettype none
`include "opq_params.svh"

module operand_queue_assert import opq_pkg::*; (
  input logic       clk_i,
  input logic       rst_ni,
  // Outstanding credits inside the input buffer
  input logic [$clog2(`OPQ_DATA_DEPTH + 1)-1:0] credit_i,
  input logic       valid_o,
  input logic       operand_ready_i,
  input data_word_t operand_o,
  input target_fu_e target_fu_o
);

  // Every issued word must find a slot, so the count stays within the depth
  credit_within_depth: assert property (@(posedge clk_i) disable iff (!rst_ni)
    credit_i <= `OPQ_DATA_DEPTH)
    else $error("credit count above the data FIFO depth");

  // Stalled beat stays on the outputs unchanged
  stall_holds_beat: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (valid_o && !operand_ready_i) |=>
      (valid_o && $stable(operand_o) && $stable(target_fu_o)))
    else $error("output beat changed under back-pressure");

  // A presented operand is always fully defined
  valid_data_known: assert property (@(posedge clk_i) disable iff (!rst_ni)
    valid_o |-> !$isunknown(operand_o))
    else $error("unknown operand while valid");

endmodule

bind operand_queue operand_queue_assert i_assert (.*, .credit_i(i_input_buffer.credit_q));

`default_nettype wire

// File: logic/operand_queue.sv
`timescale 1ns/100ps
`default_nettype none
`include "opq_params.svh"

module operand_queue import opq_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  // Command from the requester
  input  opq_cmd_t   cmd_i,
  input  logic       cmd_valid_i,
  // Register-file side
  input  data_word_t operand_i,
  input  logic       operand_valid_i,
  input  logic       operand_issued_i,
  output logic       ready_o,
  // Functional-unit side
  output data_word_t operand_o,
  output target_fu_e target_fu_o,
  output logic       valid_o,
  input  logic       operand_ready_i
);

  opq_cmd_t   cmd_head;
  logic       cmd_empty;
  logic       cmd_pop;
  data_word_t ibuf_head;
  logic       ibuf_empty;
  logic       data_pop;
  byte_sel_t  sel;

  ////////////////////////////////////////////////////////////////////////////
  // Buffers
  ////////////////////////////////////////////////////////////////////////////

  // Requester keeps pushes within the depth
  opq_fifo #(
    .WIDTH ($bits(opq_cmd_t)),
    .DEPTH (`OPQ_CMD_DEPTH)
  ) i_cmd_buffer (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (cmd_valid_i),
    .data_i  (cmd_i),
    .pop_i   (cmd_pop),
    .data_o  (cmd_head),
    .empty_o (cmd_empty),
    .full_o  ()
  );

  opq_input_buffer i_input_buffer (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .operand_i        (operand_i),
    .operand_valid_i  (operand_valid_i),
    .operand_issued_i (operand_issued_i),
    .pop_i            (data_pop),
    .ready_o          (ready_o),
    .head_o           (ibuf_head),
    .empty_o          (ibuf_empty)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Widening and issue
  ////////////////////////////////////////////////////////////////////////////

  opq_extender i_extender (
    .word_i (ibuf_head),
    .cmd_i  (cmd_head),
    .sel_i  (sel),
    .word_o (operand_o)
  );

  opq_issue_ctrl i_issue_ctrl (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .cmd_i           (cmd_head),
    .cmd_empty_i     (cmd_empty),
    .data_empty_i    (ibuf_empty),
    .operand_ready_i (operand_ready_i),
    .valid_o         (valid_o),
    .sel_o           (sel),
    .data_pop_o      (data_pop),
    .cmd_pop_o       (cmd_pop)
  );

  // Tag follows the command at the head
  assign target_fu_o = cmd_head.target_fu;

endmodule

`default_nettype wire

// File: logic/opq_issue_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module opq_issue_ctrl import opq_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  opq_cmd_t  cmd_i,
  input  logic      cmd_empty_i,
  input  logic      data_empty_i,
  input  logic      operand_ready_i,
  output logic      valid_o,
  output byte_sel_t sel_o,
  output logic      data_pop_o,
  output logic      cmd_pop_o
);

  logic [1:0] wlog;
  // log2 of the elements carried per beat
  logic [1:0] elem_shift;
  logic       xfer;

  // Elements already sent for the current command
  vl_t        cnt_q;
  vl_t        cnt_d;
  // Byte position in the head word
  byte_sel_t  sel_q;
  byte_sel_t  sel_d;

  assign wlog = widen_log(cmd_i);

  // A word never leaves without its command
  assign valid_o = !cmd_empty_i && !data_empty_i;
  assign xfer    = valid_o && operand_ready_i;
  assign sel_o   = sel_q;

  // 64/E elements per word, divided by the factor
  assign elem_shift = 2'd3 - cmd_i.eew - wlog;

  ////////////////////////////////////////////////////////////////////////////
  // Beat accounting
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    cnt_d      = cnt_q;
    sel_d      = sel_q;
    data_pop_o = 1'b0;
    cmd_pop_o  = 1'b0;

    // Nothing moves under back-pressure
    if (xfer) begin
      cnt_d = cnt_q + (vl_t'(1) << elem_shift);
      // Advance by 8/F bytes
      // Pass-through adds 8 and so stays at zero
      sel_d = sel_q + byte_sel_t'(4'd8 >> wlog);

      // Word used up once the select wraps
      data_pop_o = (sel_d == '0);

      // Last beat, possibly partial
      if (cnt_d >= cmd_i.vl) begin
        data_pop_o = 1'b1;
        cmd_pop_o  = 1'b1;
        cnt_d      = '0;
        sel_d      = '0;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
      sel_q <= '0;
    end else begin
      cnt_q <= cnt_d;
      sel_q <= sel_d;
    end
  end

endmodule

`default_nettype wire

// File: logic/opq_extender.sv
`timescale 1ns/100ps
`default_nettype none

module opq_extender import opq_pkg::*; (
  input  data_word_t word_i,
  input  opq_cmd_t   cmd_i,
  input  byte_sel_t  sel_i,
  output data_word_t word_o
);

  localparam int unsigned DW = $bits(data_word_t);

  // log2 of the widening factor, zero means pass-through
  logic [1:0] wlog;
  // Sign or zero fill
  logic       sext;
  // Head word with the selected byte moved to bit 0
  data_word_t shifted;

  // log2 of source and result element widths in bits
  int unsigned src_log;
  int unsigned dst_log;

  assign wlog = widen_log(cmd_i);

  always_comb begin
    case (cmd_i.conv)
      SEXT2, SEXT4, SEXT8: sext = 1'b1;
      default:             sext = 1'b0;
    endcase
  end

  // Source element (sel*8/E + j) becomes element j of the result
  assign shifted = word_i >> {sel_i, 3'b000};

  // EW8 is 2^3 bits, each step of eew doubles it
  assign src_log = int'(cmd_i.eew) + 3;
  assign dst_log = src_log + int'(wlog);

  ////////////////////////////////////////////////////////////////////////////
  // Bitwise widening
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    int unsigned pos;
    int unsigned base;
    int unsigned src_w;

    // Pass-through and unsupported pairs keep the word
    word_o = word_i;
    pos    = 0;
    base   = 0;
    src_w  = 1 << src_log;

    if (wlog != 2'd0) begin
      for (int unsigned b = 0; b < DW; b++) begin
        // Bit position inside the wide result element
        pos  = b & ((1 << dst_log) - 1);
        // Start of the matching narrow source element
        base = (b >> dst_log) << src_log;
        if (pos < src_w) begin
          word_o[b] = shifted[base + pos];
        end else begin
          // Upper part takes the source MSB, or zero
          word_o[b] = sext & shifted[base + src_w - 1];
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/opq_input_buffer.sv
`timescale 1ns/100ps
`default_nettype none
`include "opq_params.svh"

module opq_input_buffer import opq_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  data_word_t operand_i,
  input  logic       operand_valid_i,
  input  logic       operand_issued_i,
  input  logic       pop_i,
  output logic       ready_o,
  output data_word_t head_o,
  output logic       empty_o
);

  localparam int unsigned CRED_W = $clog2(`OPQ_DATA_DEPTH + 1);

  // Outstanding words, issued or buffered
  logic [CRED_W-1:0] credit_q;
  logic [CRED_W-1:0] credit_d;

  // Word storage
  opq_fifo #(
    .WIDTH (`OPQ_DATA_WIDTH),
    .DEPTH (`OPQ_DATA_DEPTH)
  ) i_data_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (operand_valid_i),
    .data_i  (operand_i),
    .pop_i   (pop_i),
    .data_o  (head_o),
    .empty_o (empty_o),
    .full_o  ()
  );

  ////////////////////////////////////////////////////////////////////////////
  // Credit counter
  ////////////////////////////////////////////////////////////////////////////

  // A request takes a slot at issue time, so the word always finds room
  always_comb begin
    credit_d = credit_q;
    if (operand_issued_i) begin
      credit_d = credit_d + 1'b1;
    end
    // Slot handed back when the word leaves
    if (pop_i) begin
      credit_d = credit_d - 1'b1;
    end
  end

  // Registered count, so ready follows one cycle after issue or pop
  assign ready_o = (credit_q < CRED_W'(`OPQ_DATA_DEPTH));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      credit_q <= '0;
    end else begin
      credit_q <= credit_d;
    end
  end

endmodule

`default_nettype wire

// File: logic/opq_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module opq_fifo #(
  parameter int unsigned WIDTH = 8,
  parameter int unsigned DEPTH = 2
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             push_i,
  input  logic [WIDTH-1:0] data_i,
  input  logic             pop_i,
  output logic [WIDTH-1:0] data_o,
  output logic             empty_o,
  output logic             full_o
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  // Storage array
  logic [WIDTH-1:0] mem_q [DEPTH];

  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] usage_q;
  logic             push_ok;
  logic             pop_ok;

  assign empty_o = (usage_q == '0);
  assign full_o  = (usage_q == CNT_W'(DEPTH));

  // Head is read straight out of the array
  assign data_o = mem_q[rd_ptr_q];

  // Overflow and underflow requests are dropped
  assign push_ok = push_i && !full_o;
  assign pop_ok  = pop_i && !empty_o;

  always_ff @(posedge clk_i) begin
    if (push_ok) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Pointers and usage
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      usage_q  <= '0;
    end else begin
      // Pointers wrap at DEPTH, which need not be a power of two
      if (push_ok) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_ok) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // Simultaneous push and pop leaves the usage alone
      if (push_ok && !pop_ok) begin
        usage_q <= usage_q + 1'b1;
      end else if (pop_ok && !push_ok) begin
        usage_q <= usage_q - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/opq_pkg.sv
`default_nettype none
`include "opq_params.svh"

package opq_pkg;

  // One register-file word and an element count
  typedef logic [`OPQ_DATA_WIDTH-1:0] data_word_t;
  typedef logic [`OPQ_VL_WIDTH-1:0]   vl_t;

  // Byte offset into the current source word
  typedef logic [2:0] byte_sel_t;

  // Source element width
  typedef enum logic [1:0] {EW8, EW16, EW32, EW64} eew_e;

  // Widening mode, factor 2, 4 or 8
  typedef enum logic [2:0] {CONV_NONE, SEXT2, SEXT4, SEXT8, ZEXT2, ZEXT4, ZEXT8} conv_e;

  // Consumer of the operand
  typedef enum logic {FU_ALU, FU_MFPU} target_fu_e;

  // Command from the requester
  typedef struct packed {
    conv_e      conv;
    eew_e       eew;
    vl_t        vl;
    target_fu_e target_fu;
  } opq_cmd_t;

  // log2 of the widening factor, zero for pass-through
  // Combinations whose result would not fit in one word fall back to zero
  function automatic logic [1:0] widen_log(opq_cmd_t cmd);
    logic [1:0] flog;
    case (cmd.conv)
      SEXT2, ZEXT2: flog = 2'd1;
      SEXT4, ZEXT4: flog = 2'd2;
      SEXT8, ZEXT8: flog = 2'd3;
      default:      flog = 2'd0;
    endcase
    if (({1'b0, cmd.eew} + {1'b0, flog}) > 3'd3) begin
      flog = 2'd0;
    end
    return flog;
  endfunction

endpackage

`default_nettype wire

// File: logic/opq_params.svh
`ifndef OPQ_PARAMS_SVH
`define OPQ_PARAMS_SVH

////////////////////////////////////////////////////////////////////////////
// Operand queue sizing
////////////////////////////////////////////////////////////////////////////

// Register-file word width in bits
`define OPQ_DATA_WIDTH 64

// Width of the vector-length field in a command
`define OPQ_VL_WIDTH 16

// Number of commands that can wait in the queue
`define OPQ_CMD_DEPTH 2

// Data FIFO depth, also the number of outstanding credits
`define OPQ_DATA_DEPTH 2

`endif
